// ==== source/rx_pkg.sv ====
package rx_pkg;

    ////////////////////////////////////////////////////////////////////
    // lane and datapath widths
    ////////////////////////////////////////////////////////////////////

    // time-interleaved lanes per clk_adc cycle
    localparam int NTI  = 16;
    // adc magnitude bits
    localparam int NADC = 8;
    // unfolded code width with room for sign and offset removal
    localparam int CODE_W = NADC + 2;
    // error and total counters
    localparam int CNT_W = 32;

    ////////////////////////////////////////////////////////////////////
    // prbs definitions
    ////////////////////////////////////////////////////////////////////

    // prbs7 with taps at 7 and 6 bits back in stream order
    localparam int NPRBS      = 7;
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

    // history plus one word of new bits
    localparam int EXT_W = NTI + NPRBS;

    // enough bits to count all lanes of one word
    localparam int FLAG_CNT_W = $clog2(NTI + 1);

    // vector types
    typedef logic        [NADC-1:0]       adc_mag_t;
    typedef logic signed [NADC-1:0]       offset_t;
    typedef logic signed [CODE_W-1:0]     code_t;
    typedef logic        [NTI-1:0]        lane_bits_t;
    typedef logic        [NPRBS-1:0]      prbs_state_t;
    typedef logic        [CNT_W-1:0]      count_t;
    typedef logic        [EXT_W-1:0]      prbs_ext_t;
    typedef logic        [FLAG_CNT_W-1:0] flag_cnt_t;

    // generator state after reset
    localparam prbs_state_t PRBS_RESET_STATE = '1;

endpackage

// ==== source/adc_unfold_stage.sv ====
`timescale 1ns/1ps

module adc_unfold_stage (
    input  logic             clk_adc,
    input  logic             rst_n_i,
    input  rx_pkg::adc_mag_t adc_mag_i [rx_pkg::NTI-1:0],
    input  rx_pkg::lane_bits_t adc_sign_i,
    input  rx_pkg::offset_t  pfd_offset_i,
    input  logic             check_en_i,
    output rx_pkg::code_t    code_o [rx_pkg::NTI-1:0],
    output logic             check_en_o
);

    rx_pkg::code_t mag_ext [rx_pkg::NTI-1:0];
    rx_pkg::code_t code_next [rx_pkg::NTI-1:0];
    rx_pkg::code_t offset_ext;

    // sign extend the offset once for all lanes
    assign offset_ext = rx_pkg::code_t'(pfd_offset_i);

    ////////////////////////////////////////////////////////////////////
    // sign-magnitude to two's complement
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            // magnitude is unsigned so this zero extends
            mag_ext[k] = rx_pkg::code_t'(adc_mag_i[k]);
            if (adc_sign_i[k]) begin
                code_next[k] = mag_ext[k] - offset_ext;
            end else begin
                code_next[k] = -mag_ext[k] - offset_ext;
            end
        end
    end

    // code registers
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < rx_pkg::NTI; k++) begin
                code_o[k] <= '0;
            end
        end else begin
            for (int k = 0; k < rx_pkg::NTI; k++) begin
                code_o[k] <= code_next[k];
            end
        end
    end

    // enable follows the data by one stage
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            check_en_o <= 1'b0;
        end else begin
            check_en_o <= check_en_i;
        end
    end

endmodule

// ==== source/slicer_stage.sv ====
`timescale 1ns/1ps

module slicer_stage (
    input  logic               clk_adc,
    input  logic               rst_n_i,
    input  rx_pkg::code_t      code_i [rx_pkg::NTI-1:0],
    input  rx_pkg::offset_t    slice_thresh_i,
    input  logic               check_en_i,
    output rx_pkg::lane_bits_t bits_o,
    output logic               check_en_o
);

    rx_pkg::code_t      thresh_ext;
    rx_pkg::lane_bits_t bits_next;

    // threshold widened to the code width, keeping its sign
    assign thresh_ext = rx_pkg::code_t'(slice_thresh_i);

    ////////////////////////////////////////////////////////////////////
    // per-lane decision
    ////////////////////////////////////////////////////////////////////

    // strictly above threshold slices to one
    always_comb begin
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            bits_next[k] = (code_i[k] > thresh_ext);
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= bits_next;
        end
    end

    // second enable delay
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            check_en_o <= 1'b0;
        end else begin
            check_en_o <= check_en_i;
        end
    end

endmodule

// ==== source/prbs_bist_gen.sv ====
`timescale 1ns/1ps

module prbs_bist_gen (
    input  logic                clk_adc,
    input  logic                rst_n_i,
    input  logic                bist_load_i,
    input  rx_pkg::prbs_state_t bist_seed_i,
    input  logic                bist_inj_err_i,
    output rx_pkg::lane_bits_t  bits_o
);

    rx_pkg::prbs_state_t state_q;
    rx_pkg::prbs_ext_t   ext;
    rx_pkg::lane_bits_t  word_next;
    rx_pkg::lane_bits_t  inj_mask;

    ////////////////////////////////////////////////////////////////////
    // unrolled prbs7 over one word
    ////////////////////////////////////////////////////////////////////

    // ext[0] is the oldest history bit and ext[NPRBS+k] is lane k
    always_comb begin
        ext = '0;
        ext[rx_pkg::NPRBS-1:0] = state_q;
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            ext[k + rx_pkg::NPRBS] = ext[k + rx_pkg::NPRBS - rx_pkg::PRBS_TAP_A] ^
                                     ext[k + rx_pkg::NPRBS - rx_pkg::PRBS_TAP_B];
        end
    end

    assign word_next = ext[rx_pkg::EXT_W-1:rx_pkg::NPRBS];

    // inject flips lane 0 of the output word only
    always_comb begin
        inj_mask    = '0;
        inj_mask[0] = bist_inj_err_i;
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= rx_pkg::PRBS_RESET_STATE;
            bits_o  <= '0;
        end else begin
            bits_o <= word_next ^ inj_mask;
            // seed overrides the history and the next word starts from it
            if (bist_load_i) begin
                state_q <= bist_seed_i;
            end else begin
                state_q <= ext[rx_pkg::EXT_W-1:rx_pkg::NTI];
            end
        end
    end

endmodule

// ==== source/prbs_checker_stage.sv ====
`timescale 1ns/1ps

module prbs_checker_stage (
    input  logic                clk_adc,
    input  logic                rst_n_i,
    input  rx_pkg::lane_bits_t  adc_bits_i,
    input  rx_pkg::lane_bits_t  bist_bits_i,
    input  logic                sel_bist_i,
    input  logic                check_en_i,
    input  logic                clear_i,
    output rx_pkg::lane_bits_t  err_flags_o,
    output rx_pkg::count_t      err_count_o,
    output rx_pkg::count_t      total_count_o
);

    rx_pkg::lane_bits_t  rx_bits;
    rx_pkg::prbs_state_t hist_q;
    rx_pkg::prbs_ext_t   ext;
    rx_pkg::lane_bits_t  pred_bits;
    rx_pkg::lane_bits_t  mismatch;
    rx_pkg::flag_cnt_t   num_err;

    function automatic rx_pkg::flag_cnt_t count_ones(input rx_pkg::lane_bits_t v);
        rx_pkg::flag_cnt_t n;
        n = '0;
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            n = n + rx_pkg::flag_cnt_t'(v[k]);
        end
        return n;
    endfunction

    // source select
    assign rx_bits = sel_bist_i ? bist_bits_i : adc_bits_i;

    ////////////////////////////////////////////////////////////////////
    // self-synchronizing prediction
    ////////////////////////////////////////////////////////////////////

    // received word on top of the last 7 received bits
    assign ext = {rx_bits, hist_q};

    always_comb begin
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            pred_bits[k] = ext[k + rx_pkg::NPRBS - rx_pkg::PRBS_TAP_A] ^
                           ext[k + rx_pkg::NPRBS - rx_pkg::PRBS_TAP_B];
        end
    end

    assign mismatch = rx_bits ^ pred_bits;
    assign num_err  = count_ones(mismatch);

    // history tracks the stream whether enabled or not
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else begin
            hist_q <= rx_bits[rx_pkg::NTI-1:rx_pkg::NTI-rx_pkg::NPRBS];
        end
    end

    // flags
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_flags_o <= '0;
        end else if (check_en_i) begin
            err_flags_o <= mismatch;
        end else begin
            err_flags_o <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////

    // clear wins over counting
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (clear_i) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (check_en_i) begin
            err_count_o   <= err_count_o + rx_pkg::count_t'(num_err);
            total_count_o <= total_count_o + rx_pkg::count_t'(rx_pkg::NTI);
        end
    end

endmodule

// ==== source/rx_bert_top.sv ====
`timescale 1ns/1ps

module rx_bert_top (
    input  logic                clk_adc,
    input  logic                rst_n_i,
    input  rx_pkg::adc_mag_t    adc_mag_i [rx_pkg::NTI-1:0],
    input  rx_pkg::lane_bits_t  adc_sign_i,
    input  rx_pkg::offset_t     pfd_offset_i,
    input  rx_pkg::offset_t     slice_thresh_i,
    input  logic                check_en_i,
    input  logic                sel_bist_i,
    input  logic                clear_i,
    input  logic                bist_load_i,
    input  rx_pkg::prbs_state_t bist_seed_i,
    input  logic                bist_inj_err_i,
    output rx_pkg::lane_bits_t  err_flags_o,
    output rx_pkg::count_t      err_count_o,
    output rx_pkg::count_t      total_count_o
);

    // stage 1 outputs
    rx_pkg::code_t      code_s1 [rx_pkg::NTI-1:0];
    logic               check_en_s1;

    // stage 2 outputs
    rx_pkg::lane_bits_t bits_s2;
    logic               check_en_s2;

    // bist word in the same stage as the slicer
    rx_pkg::lane_bits_t bist_bits;

    ////////////////////////////////////////////////////////////////////
    // unfold, slice, check
    ////////////////////////////////////////////////////////////////////

    adc_unfold_stage i_adc_unfold_stage (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .adc_mag_i    (adc_mag_i),
        .adc_sign_i   (adc_sign_i),
        .pfd_offset_i (pfd_offset_i),
        .check_en_i   (check_en_i),
        .code_o       (code_s1),
        .check_en_o   (check_en_s1)
    );

    slicer_stage i_slicer_stage (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .code_i         (code_s1),
        .slice_thresh_i (slice_thresh_i),
        .check_en_i     (check_en_s1),
        .bits_o         (bits_s2),
        .check_en_o     (check_en_s2)
    );

    prbs_bist_gen i_prbs_bist_gen (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .bist_load_i    (bist_load_i),
        .bist_seed_i    (bist_seed_i),
        .bist_inj_err_i (bist_inj_err_i),
        .bits_o         (bist_bits)
    );

    prbs_checker_stage i_prbs_checker_stage (
        .clk_adc       (clk_adc),
        .rst_n_i       (rst_n_i),
        .adc_bits_i    (bits_s2),
        .bist_bits_i   (bist_bits),
        .sel_bist_i    (sel_bist_i),
        .check_en_i    (check_en_s2),
        .clear_i       (clear_i),
        .err_flags_o   (err_flags_o),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

// ==== dv/tb_rx_bert_top.sv ====
`timescale 1ns/1ps

module tb_rx_bert_top;

    localparam int NUM_ROWS      = 32;
    localparam int ROW_BYTES     = 40;
    localparam int SIGN_COL      = 8;
    localparam int MAG_COL       = 24;
    localparam int RESET_CYCLES  = 2;
    localparam int DRAIN_TIMEOUT = 16;

    logic                clk_adc;
    logic                rst_n_i;
    rx_pkg::adc_mag_t    adc_mag [rx_pkg::NTI-1:0];
    rx_pkg::lane_bits_t  adc_sign;
    rx_pkg::offset_t     pfd_offset;
    rx_pkg::offset_t     slice_thresh;
    logic                check_en;
    logic                sel_bist;
    logic                clear;
    logic                bist_load;
    rx_pkg::prbs_state_t bist_seed;
    logic                bist_inj_err;
    rx_pkg::lane_bits_t  err_flags;
    rx_pkg::count_t      err_count;
    rx_pkg::count_t      total_count;

    // one byte per field and ROW_BYTES fields per stimulus row
    logic [7:0] vec_mem [0:NUM_ROWS*ROW_BYTES-1];

    // reference model with one variable per pipeline register
    int                  m_code [rx_pkg::NTI];
    logic                m_en1;
    logic                m_en2;
    rx_pkg::lane_bits_t  m_bits;
    rx_pkg::prbs_state_t m_gen_state;
    rx_pkg::lane_bits_t  m_gen_out;
    rx_pkg::prbs_state_t m_hist;
    rx_pkg::lane_bits_t  m_flags;
    rx_pkg::count_t      m_err_cnt;
    rx_pkg::count_t      m_tot_cnt;

    rx_bert_top i_rx_bert_top (
        .clk_adc        (clk_adc),
        .rst_n_i        (rst_n_i),
        .adc_mag_i      (adc_mag),
        .adc_sign_i     (adc_sign),
        .pfd_offset_i   (pfd_offset),
        .slice_thresh_i (slice_thresh),
        .check_en_i     (check_en),
        .sel_bist_i     (sel_bist),
        .clear_i        (clear),
        .bist_load_i    (bist_load),
        .bist_seed_i    (bist_seed),
        .bist_inj_err_i (bist_inj_err),
        .err_flags_o    (err_flags),
        .err_count_o    (err_count),
        .total_count_o  (total_count)
    );

    always #10 clk_adc = ~clk_adc;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic compare_outputs();
        check_value("err_flags_o", 32'(err_flags), 32'(m_flags));
        check_value("err_count_o", err_count, m_err_cnt);
        check_value("total_count_o", total_count, m_tot_cnt);
    endtask

    // register contents right after reset release
    task automatic reset_model();
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            m_code[k] = 0;
        end
        m_en1       = 1'b0;
        m_en2       = 1'b0;
        m_bits      = '0;
        m_gen_state = 7'h7f;
        m_gen_out   = '0;
        m_hist      = '0;
        m_flags     = '0;
        m_err_cnt   = '0;
        m_tot_cnt   = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // model step for one rising edge with the last stage first
    //////////////////////////////////////////////////////////////////////

    task automatic step_model();
        rx_pkg::lane_bits_t rx_word;
        rx_pkg::lane_bits_t miss;
        rx_pkg::prbs_ext_t  rx_stream;
        rx_pkg::prbs_ext_t  gen_stream;
        int                 nerr;
        int                 n;
        // checker predicts stream bit n from bits n-7 and n-6
        rx_word   = sel_bist ? m_gen_out : m_bits;
        rx_stream = {rx_word, m_hist};
        nerr      = 0;
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            n       = k + rx_pkg::NPRBS;
            miss[k] = rx_stream[n] ^ rx_stream[n - 7] ^ rx_stream[n - 6];
            nerr    = nerr + int'(miss[k]);
        end
        m_flags = m_en2 ? miss : '0;
        if (clear) begin
            m_err_cnt = '0;
            m_tot_cnt = '0;
        end else if (m_en2) begin
            m_err_cnt = m_err_cnt + rx_pkg::count_t'(nerr);
            m_tot_cnt = m_tot_cnt + 32'd16;
        end
        m_hist = rx_word[15:9];
        // generator extends its history by one word
        gen_stream[6:0] = m_gen_state;
        for (int i = 7; i < 23; i++) begin
            gen_stream[i] = gen_stream[i - 7] ^ gen_stream[i - 6];
        end
        m_gen_out    = gen_stream[22:7];
        m_gen_out[0] = m_gen_out[0] ^ bist_inj_err;
        m_gen_state  = bist_load ? bist_seed : gen_stream[22:16];
        // slicer then unfold
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            m_bits[k] = (m_code[k] > int'(slice_thresh));
        end
        m_en2 = m_en1;
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            if (adc_sign[k]) begin
                m_code[k] = int'(adc_mag[k]) - int'(pfd_offset);
            end else begin
                m_code[k] = -int'(adc_mag[k]) - int'(pfd_offset);
            end
        end
        m_en1 = check_en;
    endtask

    task automatic drive_idle();
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            adc_mag[k] = '0;
        end
        adc_sign     = '0;
        pfd_offset   = '0;
        slice_thresh = '0;
        check_en     = 1'b0;
        sel_bist     = 1'b0;
        clear        = 1'b0;
        bist_load    = 1'b0;
        bist_seed    = '0;
        bist_inj_err = 1'b0;
    endtask

    task automatic apply_row(input int r);
        int   base;
        logic use_rand;
        base         = r * ROW_BYTES;
        sel_bist     = vec_mem[base][0];
        check_en     = vec_mem[base + 1][0];
        clear        = vec_mem[base + 2][0];
        bist_load    = vec_mem[base + 3][0];
        bist_inj_err = vec_mem[base + 4][0];
        bist_seed    = vec_mem[base + 5][6:0];
        pfd_offset   = vec_mem[base + 6];
        slice_thresh = vec_mem[base + 7];
        // rows that shift the decision point may get random magnitudes
        use_rand = ((pfd_offset != '0) || (slice_thresh != '0)) &&
                   ($urandom_range(1, 0) == 32'd1);
        for (int k = 0; k < rx_pkg::NTI; k++) begin
            adc_sign[k] = vec_mem[base + SIGN_COL + k][0];
            if (use_rand) begin
                adc_mag[k] = 8'($urandom());
            end else begin
                adc_mag[k] = vec_mem[base + MAG_COL + k];
            end
        end
    endtask

    // run idle cycles until nothing is left in flight
    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        while ((m_en1 || m_en2 || (err_flags != '0)) && (cycles < DRAIN_TIMEOUT)) begin
            @(negedge clk_adc);
            step_model();
            compare_outputs();
            cycles++;
        end
        if (m_en1 || m_en2 || (err_flags != '0)) begin
            $display("*** FAILED ***");
            $fatal(1, "pipeline still busy after %0d idle cycles", DRAIN_TIMEOUT);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_adc = 1'b0;
        rst_n_i = 1'b0;
        drive_idle();
        void'($urandom(32'h744d_ec98));
        $readmemh("dv/rx_bert_tests.mem", vec_mem);
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_adc);
        @(negedge clk_adc);
        rst_n_i = 1'b1;
        check_value("err_flags_o", 32'(err_flags), 32'h0);
        check_value("err_count_o", err_count, 32'h0);
        check_value("total_count_o", total_count, 32'h0);
        // the model carries the 3 edge delay from row to flags
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
            @(negedge clk_adc);
            step_model();
            compare_outputs();
        end
        drive_idle();
        drain_pipeline();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
source/rx_pkg.sv
source/adc_unfold_stage.sv
source/slicer_stage.sv
source/prbs_bist_gen.sv
source/prbs_checker_stage.sv
source/rx_bert_top.sv
dv/tb_rx_bert_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rx bert testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module tb_rx_bert_top \
    -f flist.f \
    -o tb_rx_bert_top &&
./obj_dir/tb_rx_bert_top ||
{
    echo "simulation run failed" >&2
    exit 1
}

// ==== dv/rx_bert_tests.mem ====
// row: sel_bist check_en clear bist_load bist_inj_err seed offset threshold signs[0..15]
// next line: magnitudes[0..15], lane 0 first
00 00 00 00 00 00 00 00 01 01 01 01 01 01 01 00 00 00 00 00 00 01 00 00
40 22 5a 31 18 7f 26 44 60 13 2c 55 1e 48 37 6b
00 01 00 00 00 00 00 00 00 00 00 01 01 00 00 00 00 01 00 01 00 00 00 01
2f 51 63 0e 3d 72 19 48 5b 27 6e 34 15 43 7a 20
00 01 00 00 00 00 00 00 01 01 01 00 00 01 00 00 00 01 00 01 01 00 00 01
1c 6a 38 55 23 41 7e 0f 66 2d 4b 19 70 31 5e 28
00 01 00 00 00 00 00 00 01 01 00 01 00 01 00 00 01 01 01 01 01 00 01 00
53 17 49 62 3a 0d 75 2e 44 58 21 6f 36 12 4d 7b
00 01 00 00 00 00 00 00 00 00 00 01 01 01 00 00 00 01 00 00 01 00 00 01
26 4c 71 1b 5f 33 08 6d 42 3e 57 14 69 2a 10 45
00 01 00 00 00 00 00 00 01 00 01 01 00 01 00 01 01 00 01 01 01 01 00 01
61 39 0b 74 2f 50 1d 47 68 24 7c 35 0a 5c 43 16
00 00 00 00 00 00 20 00 01 01 01 01 01 01 01 00 00 00 00 00 00 01 00 00
11 55 23 67 39 4a 0f 72 28 60 1b 44 5d 30 6e 09
00 01 00 00 00 00 20 00 00 00 00 01 01 00 00 00 00 01 00 01 00 00 00 01
30 12 44 18 50 25 61 0c 3a 40 1f 10 2e 55 09 70
00 01 00 00 00 00 00 18 01 01 01 00 00 01 00 00 00 01 00 01 01 00 00 01
60 14 33 20 41 18 2a 50 07 19 3c 48 0a 22 66 71
00 01 00 00 00 00 e0 00 01 01 00 01 00 01 00 00 01 01 01 01 01 00 01 00
45 2b 10 39 5c 21 1f 64 30 4e 12 27 58 3a 08 20
00 01 00 00 00 00 10 f0 00 00 00 01 01 01 00 00 00 01 00 00 01 00 00 01
22 35 47 00 59 6b 13 2d 3f 51 63 75 08 1a 2c 3e
00 00 00 00 00 00 00 00 01 00 01 01 00 01 00 01 01 00 01 01 01 01 00 01
61 39 0b 74 2f 50 1d 47 68 24 7c 35 0a 5c 43 16
00 00 00 00 00 00 00 00 01 01 01 01 01 01 01 00 00 00 00 00 00 01 00 00
40 22 5a 31 18 7f 26 44 60 13 2c 55 1e 48 37 6b
01 00 00 01 00 5a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
